/* source/leaf_pkg.sv */
package leaf_pkg;

    localparam int PACKET_BITS  = 49;
    localparam int PAYLOAD_BITS = 32;
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int SEQ_BITS     = 7;

    typedef logic [PACKET_BITS-1:0]  packet_t;
    typedef logic [PAYLOAD_BITS-1:0] payload_t;
    typedef logic [LEAF_BITS-1:0]    leaf_id_t;
    typedef logic [PORT_BITS-1:0]    port_id_t;
    typedef logic [SEQ_BITS-1:0]     seq_t;

    // Tree word layout
    localparam int VALID_BIT   = 48;
    localparam int LEAF_MSB    = 47;
    localparam int LEAF_LSB    = 43;
    localparam int PORT_MSB    = 42;
    localparam int PORT_LSB    = 39;
    localparam int SEQ_MSB     = 38;
    localparam int SEQ_LSB     = 32;
    localparam int PAYLOAD_MSB = 31;
    localparam int PAYLOAD_LSB = 0;

    localparam port_id_t CFG_PORT = 4'd0;   // Route table writes arrive here

    // Payload of a configuration packet
    localparam int CFG_IDX_MSB   = 3;       // Output port being written
    localparam int CFG_IDX_LSB   = 0;
    localparam int CFG_LEAF_MSB  = 8;
    localparam int CFG_LEAF_LSB  = 4;
    localparam int CFG_DPORT_MSB = 12;
    localparam int CFG_DPORT_LSB = 9;

endpackage

/* source/route_cfg_if.sv */
`timescale 1ns/10ps

interface route_cfg_if import leaf_pkg::*; ();

    logic     wr;           // One cycle per table write
    port_id_t port;         // 1-based output port
    leaf_id_t dest_leaf;
    port_id_t dest_port;

    modport src (
        output wr, port, dest_leaf, dest_port
    );

    modport dst (
        input wr, port, dest_leaf, dest_port
    );

endinterface

/* source/port_fifo.sv */
`timescale 1ns/10ps

module port_fifo #(
    parameter int WIDTH     = 32,
    parameter int FIFO_BITS = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    output logic             full,
    output logic [WIDTH-1:0] pop_data,
    output logic             pop_vld,
    input  logic             pop_ack
);

    localparam int DEPTH = 2 ** FIFO_BITS;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [FIFO_BITS:0] wr_ptr;     // Extra bit tells full from empty
    logic [FIFO_BITS:0] rd_ptr;
    logic do_push;
    logic do_pop;

    assign full = (wr_ptr[FIFO_BITS] != rd_ptr[FIFO_BITS]) &&
                  (wr_ptr[FIFO_BITS-1:0] == rd_ptr[FIFO_BITS-1:0]);
    assign pop_vld  = (wr_ptr != rd_ptr);
    assign pop_data = mem[rd_ptr[FIFO_BITS-1:0]];    // Head word, first word fall through

    assign do_push = push && !full;
    assign do_pop  = pop_vld && pop_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr[FIFO_BITS-1:0]] <= push_data;
    end

endmodule

/* source/leaf_rx.sv */
`timescale 1ns/10ps

module leaf_rx import leaf_pkg::*; #(
    parameter int LEAF_ID   = 3,
    parameter int NUM_PORTS = 2,
    parameter int FIFO_BITS = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ap_start,
    input  packet_t                din,
    output logic                   kernel_rst,
    output payload_t [NUM_PORTS:1] user_data,
    output logic [NUM_PORTS:1]     user_vld,
    input  logic [NUM_PORTS:1]     user_ack,
    route_cfg_if.src               cfg
);

    leaf_id_t           din_leaf;
    port_id_t           din_port;
    payload_t           din_payload;
    logic               hit;
    logic               cfg_hit;
    logic [NUM_PORTS:1] push_q;
    payload_t           data_q;
    logic [NUM_PORTS:1] fifo_vld;

    assign din_leaf    = din[LEAF_MSB:LEAF_LSB];
    assign din_port    = din[PORT_MSB:PORT_LSB];
    assign din_payload = din[PAYLOAD_MSB:PAYLOAD_LSB];

    assign hit     = din[VALID_BIT] && (din_leaf == leaf_id_t'(LEAF_ID));
    assign cfg_hit = hit && (din_port == CFG_PORT);

    // ************************************************************
    // Input decode, one register stage in front of the FIFOs
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            push_q     <= '0;
            cfg.wr     <= 1'b0;
            kernel_rst <= 1'b1;
        end else begin
            for (int k = 1; k <= NUM_PORTS; k++)
                push_q[k] <= hit && (din_port == port_id_t'(k));   // Ports above range fall out here
            cfg.wr <= cfg_hit;
            if (ap_start)
                kernel_rst <= 1'b0;     // Latched, stays low until rst
        end
    end

    always_ff @(posedge clk) begin
        data_q <= din_payload;
        if (cfg_hit) begin
            cfg.port      <= din_payload[CFG_IDX_MSB:CFG_IDX_LSB];
            cfg.dest_leaf <= din_payload[CFG_LEAF_MSB:CFG_LEAF_LSB];
            cfg.dest_port <= din_payload[CFG_DPORT_MSB:CFG_DPORT_LSB];
        end
    end

    // Kernel sees nothing until started, FIFOs keep filling meanwhile
    assign user_vld = fifo_vld & ~{NUM_PORTS{kernel_rst}};

    for (genvar k = 1; k <= NUM_PORTS; k++) begin : g_in_fifo
        port_fifo #(
            .WIDTH     ($bits(payload_t)),
            .FIFO_BITS (FIFO_BITS)
        ) in_fifo (
            .clk       (clk),
            .rst       (rst),
            .push      (push_q[k]),
            .push_data (data_q),
            .full      (),                  // Tree side never overfills
            .pop_data  (user_data[k]),
            .pop_vld   (fifo_vld[k]),
            .pop_ack   (user_ack[k] && !kernel_rst)
        );
    end

endmodule

/* source/leaf_tx.sv */
`timescale 1ns/10ps

module leaf_tx import leaf_pkg::*; #(
    parameter int NUM_PORTS = 2,
    parameter int FIFO_BITS = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   resend,
    input  payload_t [NUM_PORTS:1] in_data,
    input  logic [NUM_PORTS:1]     in_vld,
    output logic [NUM_PORTS:1]     in_ack,
    route_cfg_if.dst               cfg,
    output packet_t                dout
);

    payload_t [NUM_PORTS:1] fifo_data;
    logic [NUM_PORTS:1]     fifo_vld;
    logic [NUM_PORTS:1]     fifo_full;
    logic [NUM_PORTS:1]     fifo_pop;
    leaf_id_t               route_leaf [1:NUM_PORTS];
    port_id_t               route_port [1:NUM_PORTS];
    seq_t                   seq_cnt [1:NUM_PORTS];
    port_id_t               last_q;     // Previous winner
    port_id_t               grant;
    logic                   grant_vld;
    logic                   fire;

    assign in_ack = ~fifo_full;
    assign fire   = grant_vld && !resend;

    for (genvar k = 1; k <= NUM_PORTS; k++) begin : g_out_fifo
        assign fifo_pop[k] = fire && (grant == port_id_t'(k));

        port_fifo #(
            .WIDTH     ($bits(payload_t)),
            .FIFO_BITS (FIFO_BITS)
        ) out_fifo (
            .clk       (clk),
            .rst       (rst),
            .push      (in_vld[k]),
            .push_data (in_data[k]),
            .full      (fifo_full[k]),
            .pop_data  (fifo_data[k]),
            .pop_vld   (fifo_vld[k]),
            .pop_ack   (fifo_pop[k])
        );
    end

    // ************************************************************
    // Round robin, search starts one past the last winner
    // ************************************************************
    always_comb begin
        int cand;
        grant_vld = 1'b0;
        grant     = last_q;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = (int'(last_q) + i - 1) % NUM_PORTS + 1;
            if (!grant_vld && fifo_vld[cand]) begin
                grant_vld = 1'b1;
                grant     = port_id_t'(cand);
            end
        end
    end

    // Route table, default is leaf 0 and same port number
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 1; k <= NUM_PORTS; k++) begin
                route_leaf[k] <= '0;
                route_port[k] <= port_id_t'(k);
            end
        end else if (cfg.wr && cfg.port != CFG_PORT && cfg.port <= port_id_t'(NUM_PORTS)) begin
            route_leaf[cfg.port] <= cfg.dest_leaf;
            route_port[cfg.port] <= cfg.dest_port;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dout   <= '0;
            last_q <= port_id_t'(NUM_PORTS);
            for (int k = 1; k <= NUM_PORTS; k++)
                seq_cnt[k] <= '0;
        end else begin
            dout <= '0;     // Idle and resend both give an all-zero word
            if (fire) begin
                dout[VALID_BIT]               <= 1'b1;
                dout[LEAF_MSB:LEAF_LSB]       <= route_leaf[grant];
                dout[PORT_MSB:PORT_LSB]       <= route_port[grant];
                dout[SEQ_MSB:SEQ_LSB]         <= seq_cnt[grant];
                dout[PAYLOAD_MSB:PAYLOAD_LSB] <= fifo_data[grant];
                seq_cnt[grant] <= seq_cnt[grant] + 1'b1;    // Wraps at 128
                last_q         <= grant;
            end
        end
    end

endmodule

/* source/user_kernel.sv */
`timescale 1ns/10ps

module user_kernel import leaf_pkg::*; #(
    parameter int NUM_PORTS = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  payload_t [NUM_PORTS:1] in_data,
    input  logic [NUM_PORTS:1]     in_vld,
    output logic [NUM_PORTS:1]     in_ack,
    output payload_t [NUM_PORTS:1] out_data,
    output logic [NUM_PORTS:1]     out_vld,
    input  logic [NUM_PORTS:1]     out_ack
);

    // One register slice per port, result is payload plus port number
    for (genvar k = 1; k <= NUM_PORTS; k++) begin : g_slice
        logic     vld_q;
        payload_t data_q;
        logic     take;

        assign in_ack[k]   = !vld_q || out_ack[k];     // Empty or draining this cycle
        assign take        = in_vld[k] && in_ack[k];
        assign out_vld[k]  = vld_q;
        assign out_data[k] = data_q;

        always_ff @(posedge clk) begin
            if (rst)
                vld_q <= 1'b0;
            else if (take)
                vld_q <= 1'b1;
            else if (out_ack[k])
                vld_q <= 1'b0;
        end

        always_ff @(posedge clk) begin
            if (take)
                data_q <= in_data[k] + payload_t'(k);
        end
    end

endmodule

/* source/leaf.sv */
`timescale 1ns/10ps

module leaf import leaf_pkg::*; #(
    parameter int LEAF_ID   = 3,
    parameter int NUM_PORTS = 2,
    parameter int FIFO_BITS = 2
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    ap_start,
    input  logic    resend,
    input  packet_t din,
    output packet_t dout
);

    payload_t [NUM_PORTS:1] data_rx2user;
    logic [NUM_PORTS:1]     vld_rx2user;
    logic [NUM_PORTS:1]     ack_user2rx;
    payload_t [NUM_PORTS:1] data_user2tx;
    logic [NUM_PORTS:1]     vld_user2tx;
    logic [NUM_PORTS:1]     ack_tx2user;
    logic                   kernel_rst;

    route_cfg_if cfg_if ();

    leaf_rx #(
        .LEAF_ID   (LEAF_ID),
        .NUM_PORTS (NUM_PORTS),
        .FIFO_BITS (FIFO_BITS)
    ) rx (
        .clk        (clk),
        .rst        (rst),
        .ap_start   (ap_start),
        .din        (din),
        .kernel_rst (kernel_rst),
        .user_data  (data_rx2user),
        .user_vld   (vld_rx2user),
        .user_ack   (ack_user2rx),
        .cfg        (cfg_if.src)
    );

    user_kernel #(.NUM_PORTS(NUM_PORTS)) kernel (
        .clk      (clk),
        .rst      (kernel_rst),     // Held until ap_start
        .in_data  (data_rx2user),
        .in_vld   (vld_rx2user),
        .in_ack   (ack_user2rx),
        .out_data (data_user2tx),
        .out_vld  (vld_user2tx),
        .out_ack  (ack_tx2user)
    );

    leaf_tx #(
        .NUM_PORTS (NUM_PORTS),
        .FIFO_BITS (FIFO_BITS)
    ) tx (
        .clk     (clk),
        .rst     (rst),
        .resend  (resend),
        .in_data (data_user2tx),
        .in_vld  (vld_user2tx),
        .in_ack  (ack_tx2user),
        .cfg     (cfg_if.dst),
        .dout    (dout)
    );

endmodule

/* test/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
    parameter real PERIOD = 10.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

/* test/leaf_checker.sv */
`timescale 1ns/10ps

module leaf_checker import leaf_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    ap_start,
    input logic    resend,
    input logic    kernel_rst,
    input packet_t dout
);

    int          fails = 0;     // Read by the testbench
    seq_t        last_seq [16];
    logic [15:0] seen;          // Destination port has carried a packet
    port_id_t    out_port;
    seq_t        out_seq;

    assign out_port = dout[PORT_MSB:PORT_LSB];
    assign out_seq  = dout[SEQ_MSB:SEQ_LSB];

    always_ff @(posedge clk) begin
        if (rst) begin
            seen <= '0;
        end else if (dout[VALID_BIT]) begin
            seen[out_port]     <= 1'b1;
            last_seq[out_port] <= out_seq;
        end
    end

    // ************************************************************
    // Tree output rules
    // ************************************************************
    a_resend_quiet: assert property (@(posedge clk) disable iff (rst)
        $past(resend) |-> dout == '0)
        else begin
            $error("dout not zero in the cycle after resend");
            fails++;
        end

    a_no_early_out: assert property (@(posedge clk) disable iff (rst)
        kernel_rst |-> !dout[VALID_BIT])
        else begin
            $error("dout valid while the kernel is held in reset");
            fails++;
        end

    a_seq_step: assert property (@(posedge clk) disable iff (rst)
        dout[VALID_BIT] && seen[out_port] |-> out_seq == seq_t'(last_seq[out_port] + 1'b1))
        else begin
            $error("sequence on port %0d did not step by one", out_port);
            fails++;
        end

    a_start_first: assert property (@(posedge clk) disable iff (rst)
        $fell(kernel_rst) |-> $past(ap_start))
        else begin
            $error("kernel_rst fell without ap_start");
            fails++;
        end

endmodule

/* test/leaf_tb.sv */
`timescale 1ns/10ps

module leaf_tb import leaf_pkg::*; ();

    localparam int LEAF       = 3;
    localparam int PORTS      = 2;
    localparam int MAX_CYCLES = 6 * 300 + 200;     // Six tests of about 300 cycles plus margin

    logic    clk;
    logic    rst;
    logic    ap_start;
    logic    resend;
    packet_t din;
    packet_t dout;

    packet_t  exp_q [1:PORTS][$];   // Expected packets per output port
    leaf_id_t route_leaf [1:PORTS];
    port_id_t route_port [1:PORTS];
    seq_t     seq_next [1:PORTS];
    logic     started = 1'b0;
    int       errors = 0;
    int       err_mark = 0;
    int       tests_run = 0;
    int       tests_failed = 0;
    int       cycles = 0;

    tb_clock #(.PERIOD(10.0)) clock0 (.clk(clk));

    leaf dut0 (.clk, .rst, .ap_start, .resend, .din, .dout);

    bind leaf leaf_checker chk (.clk, .rst, .ap_start, .resend, .kernel_rst, .dout);

    function automatic int error_total();
        return errors + dut0.chk.fails;
    endfunction

    // Only words for this leaf and a user port are expected back
    task automatic send(int port, payload_t data, int dleaf);
        @(posedge clk);
        din <= {1'b1, leaf_id_t'(dleaf), port_id_t'(port), seq_t'(0), data};
        if (dleaf == LEAF && port >= 1 && port <= PORTS) begin
            exp_q[port].push_back({1'b1, route_leaf[port], route_port[port],
                                   seq_next[port], data + payload_t'(port)});
            seq_next[port]++;
        end
    endtask

    task automatic send_cfg(int port, int dleaf, int dport);
        send(0, payload_t'({dport[3:0], dleaf[4:0], port[3:0]}), LEAF);
        route_leaf[port] = leaf_id_t'(dleaf);
        route_port[port] = port_id_t'(dport);
    endtask

    task automatic idle();
        @(posedge clk);
        din <= '0;
    endtask

    task automatic drain(string name);
        int errs;
        idle();
        while (exp_q[1].size() + exp_q[2].size() != 0)
            @(negedge clk);
        repeat (10) @(negedge clk);     // Room for a stray packet
        errs = error_total() - err_mark;
        err_mark = error_total();
        tests_run++;
        if (errs != 0)
            tests_failed++;
        $display("test %0d, %s: %s, %0d errors", tests_run, name,
                 errs == 0 ? "passed" : "failed", errs);
    endtask

    // ************************************************************
    // Output monitor matched on destination leaf and port
    // ************************************************************
    always @(negedge clk) begin
        int k;
        packet_t exp;
        if (!rst && !dout[VALID_BIT]) begin
            assert (dout == '0) else begin
                $display("FAILED dout idle: got %h expected %h", dout, packet_t'(0));
                errors++;
            end
        end
        if (!rst && dout[VALID_BIT]) begin
            k = 0;
            for (int i = 1; i <= PORTS; i++)
                if (k == 0 && exp_q[i].size() != 0 &&
                    exp_q[i][0][LEAF_MSB:PORT_LSB] == dout[LEAF_MSB:PORT_LSB])
                    k = i;
            assert (started && k != 0) else begin
                $display("Packet %h left the leaf unexpected or before ap_start", dout);
                errors++;
            end
            if (k != 0) begin
                exp = exp_q[k].pop_front();
                assert (dout[SEQ_MSB:SEQ_LSB] == exp[SEQ_MSB:SEQ_LSB]) else begin
                    $display("FAILED dout seq port %0d: got %h expected %h", k,
                             dout[SEQ_MSB:SEQ_LSB], exp[SEQ_MSB:SEQ_LSB]);
                    errors++;
                end
                assert (dout[PAYLOAD_MSB:0] == exp[PAYLOAD_MSB:0]) else begin
                    $display("FAILED dout payload port %0d: got %h expected %h", k,
                             dout[PAYLOAD_MSB:0], exp[PAYLOAD_MSB:0]);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, traffic never drained", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h556c));
        rst = 1'b1;
        ap_start = 1'b0;
        resend = 1'b0;
        din = '0;
        for (int k = 1; k <= PORTS; k++) begin
            route_leaf[k] = '0;
            route_port[k] = port_id_t'(k);
            seq_next[k] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 4; i++)
            send(i % PORTS + 1, $urandom(), LEAF);
        repeat (20) idle();
        started = 1'b1;
        ap_start <= 1'b1;
        idle();
        ap_start <= 1'b0;
        drain("held until ap_start");

        for (int i = 0; i < 8; i++)
            send($urandom_range(PORTS, 1), $urandom(), LEAF);
        drain("default routes");

        send(1, $urandom(), 7);
        send(2, $urandom(), 12);
        send(9, $urandom(), LEAF);
        send(15, $urandom(), LEAF);
        send(1, $urandom(), LEAF);
        drain("foreign leaf and port dropped");

        send_cfg(1, 9, 10);
        send_cfg(2, 17, 11);
        for (int i = 0; i < 6; i++)
            send(i % PORTS + 1, $urandom(), LEAF);
        drain("routes reconfigured");

        for (int i = 0; i < 12; i++) begin
            send(i % PORTS + 1, $urandom(), LEAF);
            if (i == 3)
                resend <= 1'b1;
        end
        repeat (12) idle();     // Resend high for 20 edges in all
        resend <= 1'b0;
        drain("resend hold");

        for (int i = 0; i < 24; i++)
            send(i % PORTS + 1, $urandom(), LEAF);
        drain("bursts on both ports");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_total());
        if (tests_failed == 0 && error_total() == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* list.f */
source/leaf_pkg.sv
source/route_cfg_if.sv
source/port_fifo.sv
source/leaf_rx.sv
source/leaf_tx.sv
source/user_kernel.sv
source/leaf.sv
test/tb_clock.sv
test/leaf_checker.sv
test/leaf_tb.sv

/* Makefile */
TOP = leaf_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
